// File: source/hll_pkg.sv
/*
 * HyperLogLog sketch shared definitions
 * Bus widths, AXI-Lite channel structs, control and result
 * words, and the register map of the control slave.
 */
package hll_pkg;

  // -- Widths ---------------------------------------
  localparam int AXIL_DATA_BITS = 64;
  localparam int AXIL_ADDR_BITS = 8;
  localparam int ITEM_BITS      = 32;
  localparam int HASH_BITS      = 32;
  localparam int RANK_BITS      = 5;
  localparam int SUM_BITS       = 48;
  localparam int ZCNT_BITS      = 16;

  // Byte offsets of the slave registers
  localparam logic [AXIL_ADDR_BITS-1:0] REG_CTRL   = 8'h00;
  localparam logic [AXIL_ADDR_BITS-1:0] REG_STATUS = 8'h08;
  localparam logic [AXIL_ADDR_BITS-1:0] REG_RESULT = 8'h10;

  // -- AXI-Lite channels ----------------------------
  typedef struct packed {
    logic                        awvalid;
    logic [AXIL_ADDR_BITS-1:0]   awaddr;
    logic                        wvalid;
    logic [AXIL_DATA_BITS-1:0]   wdata;
    logic [AXIL_DATA_BITS/8-1:0] wstrb;
    logic                        bready;
    logic                        arvalid;
    logic [AXIL_ADDR_BITS-1:0]   araddr;
    logic                        rready;
  } axil_req_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    logic [1:0]                bresp;
    logic                      arready;
    logic                      rvalid;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic [1:0]                rresp;
  } axil_rsp_t;

  // -- Core control and result ----------------------
  typedef struct packed {
    logic clear;
    logic estimate;
  } hll_ctrl_t;

  // Zero count sits in the upper 16 bits of the result word
  typedef struct packed {
    logic [ZCNT_BITS-1:0] zero_count;
    logic [SUM_BITS-1:0]  harmonic_sum;
  } hll_result_t;

endpackage

// File: source/hll_slave.sv
/*
 * HLL control slave
 * AXI-Lite register slave with a self-clearing control register,
 * a status register and the captured estimator result.
 * Every response is OKAY.
 */
`timescale 1ns/1ns

module hll_slave (
  input  logic                aclk,
  input  logic                aresetn,
  input  hll_pkg::axil_req_t  axil_req,
  output hll_pkg::axil_rsp_t  axil_rsp,
  input  logic                result_valid,
  input  hll_pkg::hll_result_t result,
  input  logic                busy,
  output hll_pkg::hll_ctrl_t  ctrl
);

  // -- Declarations ---------------------------------
  logic                               wr_ready;
  logic                               aw_en;
  logic                               bvalid;
  logic                               arready;
  logic                               rvalid;
  logic [hll_pkg::AXIL_DATA_BITS-1:0] rdata;
  logic [hll_pkg::AXIL_DATA_BITS-1:0] rd_mux;
  logic                               wr_en;
  logic                               rd_en;
  logic                               stat_valid;
  hll_pkg::hll_result_t               result_q;

  assign wr_en = wr_ready && axil_req.awvalid && axil_req.wvalid;
  assign rd_en = arready && axil_req.arvalid && ~rvalid;

  // -- Write channel --------------------------------
  // AW and W are taken together, one transfer per response
  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
    begin
      wr_ready <= 1'b0;
      aw_en    <= 1'b1;
    end
    else if (~wr_ready && axil_req.awvalid && axil_req.wvalid && aw_en)
    begin
      wr_ready <= 1'b1;
      aw_en    <= 1'b0;
    end
    else
    begin
      wr_ready <= 1'b0;
      if (axil_req.bready && bvalid)
        aw_en <= 1'b1;
    end
  end

  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
      bvalid <= 1'b0;
    else if (wr_en && ~bvalid)
      bvalid <= 1'b1;
    else if (axil_req.bready && bvalid)
      bvalid <= 1'b0;
  end

  // Control bits are pulses, cleared the cycle after the write
  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
      ctrl <= '0;
    else
    begin
      ctrl <= '0;
      if (wr_en && axil_req.awaddr == hll_pkg::REG_CTRL && axil_req.wstrb[0])
      begin
        ctrl.clear    <= axil_req.wdata[0];
        ctrl.estimate <= axil_req.wdata[1];
      end
    end
  end

  // -- Status and result ----------------------------
  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
    begin
      stat_valid <= 1'b0;
      result_q   <= '0;
    end
    else if (result_valid)
    begin
      stat_valid <= 1'b1;
      result_q   <= result;
    end
    else if (ctrl.clear || ctrl.estimate)
      stat_valid <= 1'b0;
  end

  // -- Read channel ---------------------------------
  always_comb
  begin
    rd_mux = '0;
    case (axil_req.araddr)
      hll_pkg::REG_STATUS: rd_mux[1:0] = {busy, stat_valid};
      hll_pkg::REG_RESULT: rd_mux      = result_q;
      default:             rd_mux      = '0;
    endcase
  end

  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
      arready <= 1'b0;
    else
      arready <= ~arready && axil_req.arvalid;
  end

  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
    begin
      rvalid <= 1'b0;
      rdata  <= '0;
    end
    else if (rd_en)
    begin
      rvalid <= 1'b1;
      rdata  <= rd_mux;
    end
    else if (rvalid && axil_req.rready)
      rvalid <= 1'b0;
  end

  // -- Outputs --------------------------------------
  assign axil_rsp.awready = wr_ready;
  assign axil_rsp.wready  = wr_ready;
  assign axil_rsp.bvalid  = bvalid;
  assign axil_rsp.bresp   = 2'b00;
  assign axil_rsp.arready = arready;
  assign axil_rsp.rvalid  = rvalid;
  assign axil_rsp.rdata   = rdata;
  assign axil_rsp.rresp   = 2'b00;

endmodule

// File: source/hll_item_port.sv
/*
 * HLL item port
 * Four-phase req/ack receiver, one item strobe per exchange.
 */
`timescale 1ns/1ns

module hll_item_port (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          item_req,
  input  logic [hll_pkg::ITEM_BITS-1:0] item_data,
  output logic                          item_ack,
  input  logic                          hold,
  output logic                          item_valid,
  output logic [hll_pkg::ITEM_BITS-1:0] item
);

  typedef enum logic {
    S_IDLE,
    S_ACKED
  } state_t;

  state_t state;

  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
    begin
      state      <= S_IDLE;
      item_valid <= 1'b0;
    end
    else
    begin
      item_valid <= 1'b0;
      case (state)
        S_IDLE:
          // Refuse new exchanges while the estimator holds us off
          if (item_req && !hold)
          begin
            state      <= S_ACKED;
            item_valid <= 1'b1;
          end
        S_ACKED:
          if (!item_req)
            state <= S_IDLE;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Data is stable while req is high
  always_ff @(posedge aclk)
  begin
    if (state == S_IDLE && item_req && !hold)
      item <= item_data;
  end

  assign item_ack = (state == S_ACKED);

endmodule

// File: source/hll_hash.sv
/*
 * HLL hash
 * MurmurHash3 32-bit finalizer, three register stages,
 * one item accepted per cycle.
 */
`timescale 1ns/1ns

module hll_hash (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          in_valid,
  input  logic [hll_pkg::ITEM_BITS-1:0] in_data,
  output logic                          out_valid,
  output logic [hll_pkg::HASH_BITS-1:0] out_hash,
  output logic                          pipe_busy
);

  localparam logic [31:0] C1 = 32'h85eb_ca6b;
  localparam logic [31:0] C2 = 32'hc2b2_ae35;

  logic [2:0]                    stg_valid;
  logic [hll_pkg::HASH_BITS-1:0] stg1;
  logic [hll_pkg::HASH_BITS-1:0] stg2;
  logic [hll_pkg::HASH_BITS-1:0] stg3;

  // Valid bits follow the data down the pipe
  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
      stg_valid <= '0;
    else
      stg_valid <= {stg_valid[1:0], in_valid};
  end

  always_ff @(posedge aclk)
  begin
    stg1 <= (in_data ^ (in_data >> 16)) * C1;
    stg2 <= (stg1 ^ (stg1 >> 13)) * C2;
    stg3 <= stg2 ^ (stg2 >> 16);
  end

  assign out_valid = stg_valid[2];
  assign out_hash  = stg3;

  // Input strobe counts too, so a just-captured item is not missed
  assign pipe_busy = in_valid || (|stg_valid);

endmodule

// File: source/hll_sketch.sv
/*
 * HLL sketch
 * Bucket register file. Each hash selects a bucket by its top
 * bits and keeps the running maximum rank of the rest.
 * Combinational scan read port for the estimator.
 */
`timescale 1ns/1ns

module hll_sketch #(
  parameter int IDX_BITS = 4
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          clear,
  input  logic                          hash_valid,
  input  logic [hll_pkg::HASH_BITS-1:0] hash,
  input  logic [IDX_BITS-1:0]           scan_idx,
  output logic [hll_pkg::RANK_BITS-1:0] scan_value
);

  localparam int NUM_BUCKETS = 1 << IDX_BITS;
  localparam int REM_BITS    = hll_pkg::HASH_BITS - IDX_BITS;

  logic [hll_pkg::RANK_BITS-1:0] bucket [NUM_BUCKETS];
  logic [IDX_BITS-1:0]           upd_idx;
  logic [REM_BITS-1:0]           upd_rem;
  logic [hll_pkg::RANK_BITS-1:0] upd_rank;

  // Leading zero count plus one, all zeros gives REM_BITS+1
  function automatic logic [hll_pkg::RANK_BITS-1:0] rank_of(
    input logic [REM_BITS-1:0] bits
  );
    logic [hll_pkg::RANK_BITS-1:0] r;
    r = hll_pkg::RANK_BITS'(REM_BITS + 1);
    for (int i = 0; i < REM_BITS; i++)
    begin
      if (bits[i])
        r = hll_pkg::RANK_BITS'(REM_BITS - i);
    end
    return r;
  endfunction

  // -- Hash split -----------------------------------
  assign upd_idx  = hash[hll_pkg::HASH_BITS-1 -: IDX_BITS];
  assign upd_rem  = hash[REM_BITS-1:0];
  assign upd_rank = rank_of(upd_rem);

  // -- Bucket update --------------------------------
  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
    begin
      for (int i = 0; i < NUM_BUCKETS; i++)
        bucket[i] <= '0;
    end
    else if (clear)
    begin
      for (int i = 0; i < NUM_BUCKETS; i++)
        bucket[i] <= '0;
    end
    else if (hash_valid && upd_rank > bucket[upd_idx])
      bucket[upd_idx] <= upd_rank;
  end

  assign scan_value = bucket[scan_idx];

endmodule

// File: source/hll_estimator.sv
/*
 * HLL estimator
 * Waits for the hash pipe to drain, then scans every bucket,
 * summing 2^(rem+1-value) and counting empty buckets.
 */
`timescale 1ns/1ns

module hll_estimator #(
  parameter int IDX_BITS = 4
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          estimate,
  input  logic                          clear,
  input  logic                          pipe_busy,
  output logic [IDX_BITS-1:0]           scan_idx,
  input  logic [hll_pkg::RANK_BITS-1:0] scan_value,
  output logic                          hold,
  output logic                          busy,
  output logic                          result_valid,
  output hll_pkg::hll_result_t          result
);

  localparam int                  EXP_MAX  = hll_pkg::HASH_BITS - IDX_BITS + 1;
  localparam logic [IDX_BITS-1:0] LAST_IDX = '1;

  typedef enum logic [1:0] {
    S_IDLE,
    S_DRAIN,
    S_SCAN
  } state_t;

  state_t                        state;
  logic [hll_pkg::SUM_BITS-1:0]  sum_acc;
  logic [hll_pkg::SUM_BITS-1:0]  sum_next;
  logic [hll_pkg::ZCNT_BITS-1:0] zcnt_acc;
  logic [hll_pkg::ZCNT_BITS-1:0] zcnt_next;

  assign sum_next  = sum_acc + (hll_pkg::SUM_BITS'(1) << (EXP_MAX - int'(scan_value)));
  assign zcnt_next = zcnt_acc + hll_pkg::ZCNT_BITS'(scan_value == '0);

  // -- Sequencer ------------------------------------
  always_ff @(posedge aclk, negedge aresetn)
  begin
    if (!aresetn)
    begin
      state        <= S_IDLE;
      scan_idx     <= '0;
      result_valid <= 1'b0;
    end
    else
    begin
      result_valid <= 1'b0;
      if (clear)
        state <= S_IDLE;
      else
        case (state)
          S_IDLE:
            if (estimate)
              state <= S_DRAIN;
          S_DRAIN:
            if (!pipe_busy)
            begin
              state    <= S_SCAN;
              scan_idx <= '0;
            end
          S_SCAN:
          begin
            scan_idx <= scan_idx + 1'b1;
            if (scan_idx == LAST_IDX)
            begin
              state        <= S_IDLE;
              result_valid <= 1'b1;
            end
          end
          default: state <= S_IDLE;
        endcase
    end
  end

  // -- Accumulators ---------------------------------
  always_ff @(posedge aclk)
  begin
    if (state == S_DRAIN)
    begin
      sum_acc  <= '0;
      zcnt_acc <= '0;
    end
    else if (state == S_SCAN)
    begin
      sum_acc  <= sum_next;
      zcnt_acc <= zcnt_next;
      if (scan_idx == LAST_IDX)
      begin
        result.zero_count   <= zcnt_next;
        result.harmonic_sum <= sum_next;
      end
    end
  end

  // Items stay out for the whole drain and scan
  assign busy = (state != S_IDLE);
  assign hold = (state != S_IDLE);

endmodule

// File: source/hll_top.sv
/*
 * HLL top
 * HyperLogLog sketch with AXI-Lite control and a four-phase
 * item port.
 */
`timescale 1ns/1ns

module hll_top #(
  parameter int IDX_BITS = 4
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  hll_pkg::axil_req_t            axil_req,
  output hll_pkg::axil_rsp_t            axil_rsp,
  input  logic                          item_req,
  input  logic [hll_pkg::ITEM_BITS-1:0] item_data,
  output logic                          item_ack
);

  // -- Internal wires -------------------------------
  hll_pkg::hll_ctrl_t            ctrl;
  hll_pkg::hll_result_t          result;
  logic                          result_valid;
  logic                          busy;
  logic                          hold;
  logic                          item_valid;
  logic [hll_pkg::ITEM_BITS-1:0] item;
  logic                          hash_valid;
  logic [hll_pkg::HASH_BITS-1:0] hash;
  logic                          pipe_busy;
  logic [IDX_BITS-1:0]           scan_idx;
  logic [hll_pkg::RANK_BITS-1:0] scan_value;

  hll_slave u_slave (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .axil_req     (axil_req),
    .axil_rsp     (axil_rsp),
    .result_valid (result_valid),
    .result       (result),
    .busy         (busy),
    .ctrl         (ctrl)
  );

  hll_item_port u_item_port (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .item_req   (item_req),
    .item_data  (item_data),
    .item_ack   (item_ack),
    .hold       (hold),
    .item_valid (item_valid),
    .item       (item)
  );

  hll_hash u_hash (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (item_valid),
    .in_data   (item),
    .out_valid (hash_valid),
    .out_hash  (hash),
    .pipe_busy (pipe_busy)
  );

  hll_sketch #(.IDX_BITS(IDX_BITS)) u_sketch (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .clear      (ctrl.clear),
    .hash_valid (hash_valid),
    .hash       (hash),
    .scan_idx   (scan_idx),
    .scan_value (scan_value)
  );

  hll_estimator #(.IDX_BITS(IDX_BITS)) u_estimator (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .estimate     (ctrl.estimate),
    .clear        (ctrl.clear),
    .pipe_busy    (pipe_busy),
    .scan_idx     (scan_idx),
    .scan_value   (scan_value),
    .hold         (hold),
    .busy         (busy),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// File: testbench/hll_tb.sv
/*
 * HLL sketch testbench
 * Drives the AXI-Lite control slave and the four-phase item port,
 * keeps a reference bucket array and checks every estimate.
 */
`timescale 1ns/1ns

module hll_tb;

  localparam int IDX_BITS    = 4;
  localparam int NUM_BUCKETS = 1 << IDX_BITS;
  localparam int REM_BITS    = hll_pkg::HASH_BITS - IDX_BITS;
  localparam int NUM_ITEMS   = 200;
  localparam int NUM_TESTS   = 6;
  // Single item plus two passes of the random set
  localparam int CYCLE_LIMIT = 40 * (2 * NUM_ITEMS + 1) + 200 * NUM_TESTS;

  localparam logic [63:0] EMPTY_RESULT = {
    hll_pkg::ZCNT_BITS'(NUM_BUCKETS),
    hll_pkg::SUM_BITS'(NUM_BUCKETS) << (REM_BITS + 1)
  };

  logic                          aclk;
  logic                          aresetn;
  hll_pkg::axil_req_t            axil_req;
  hll_pkg::axil_rsp_t            axil_rsp;
  logic                          item_req;
  logic [hll_pkg::ITEM_BITS-1:0] item_data;
  logic                          item_ack;

  int          cycle_cnt;
  int          check_cnt;
  int          mismatch_cnt;
  int          fail_tests;
  int          test_start_mm;
  int          cmp_req_cnt;
  int          cmp_ack_cnt;
  logic [63:0] cmp_got;
  logic [63:0] cmp_exp;
  string       cmp_what;
  int          ref_bucket [NUM_BUCKETS];
  logic [31:0] items [NUM_ITEMS];
  logic [31:0] lfsr_state;
  logic [63:0] rd_data;
  logic [63:0] saved_result;

  hll_top #(.IDX_BITS(IDX_BITS)) u_hll_top (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .item_req  (item_req),
    .item_data (item_data),
    .item_ack  (item_ack)
  );

  initial aclk = 1'b0;
  always #20 aclk = ~aclk;

  // Watchdog
  always @(posedge aclk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("timeout: no progress within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  // Compare process, one pending check at a time
  always @(negedge aclk)
  begin
    if (cmp_ack_cnt != cmp_req_cnt)
    begin
      check_cnt = check_cnt + 1;
      assert (cmp_got === cmp_exp)
      else
      begin
        mismatch_cnt = mismatch_cnt + 1;
        $display("MISMATCH at %0t ns: %s read %h, expected %h",
                 $time, cmp_what, cmp_got, cmp_exp);
      end
      cmp_ack_cnt = cmp_req_cnt;
    end
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic logic [31:0] fmix32(input logic [31:0] key);
    logic [31:0] h;
    h = key;
    h = h ^ (h >> 16);
    h = h * 32'h85eb_ca6b;
    h = h ^ (h >> 13);
    h = h * 32'hc2b2_ae35;
    h = h ^ (h >> 16);
    return h;
  endfunction

  // Leading zeros below the bucket index, plus one
  function automatic int rank_of(input logic [31:0] h);
    int r;
    r = 1;
    for (int b = REM_BITS - 1; b >= 0 && !h[b]; b--)
      r++;
    return r;
  endfunction

  function automatic logic [63:0] ref_result();
    logic [hll_pkg::ZCNT_BITS-1:0] zeros;
    logic [hll_pkg::SUM_BITS-1:0]  sum;
    zeros = '0;
    sum   = '0;
    for (int i = 0; i < NUM_BUCKETS; i++)
    begin
      if (ref_bucket[i] == 0)
        zeros = zeros + 16'd1;
      sum = sum + (hll_pkg::SUM_BITS'(1) << (REM_BITS + 1 - ref_bucket[i]));
    end
    return {zeros, sum};
  endfunction

  task automatic ref_add(input logic [31:0] item);
    logic [31:0] h;
    int          idx;
    int          r;
    h   = fmix32(item);
    idx = int'(h >> REM_BITS);
    r   = rank_of(h);
    if (r > ref_bucket[idx])
      ref_bucket[idx] = r;
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    // Taps 32, 22, 2, 1
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // --------------------------------------------------
  // Bus and item drivers
  // --------------------------------------------------
  task automatic axil_write(input logic [7:0] addr, input logic [63:0] data);
    logic [1:0] resp;
    @(posedge aclk);
    axil_req.awvalid <= 1'b1;
    axil_req.awaddr  <= addr;
    axil_req.wvalid  <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= '1;
    axil_req.bready  <= 1'b1;
    do
      @(negedge aclk);
    while (!axil_rsp.awready);
    @(posedge aclk);
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    do
      @(negedge aclk);
    while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    @(posedge aclk);
    axil_req.bready <= 1'b0;
    // Every response is OKAY
    check_value("write response", 64'(resp), 64'd0);
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [63:0] data);
    logic [1:0] resp;
    @(posedge aclk);
    axil_req.arvalid <= 1'b1;
    axil_req.araddr  <= addr;
    axil_req.rready  <= 1'b1;
    do
      @(negedge aclk);
    while (!axil_rsp.arready);
    @(posedge aclk);
    axil_req.arvalid <= 1'b0;
    do
      @(negedge aclk);
    while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge aclk);
    axil_req.rready <= 1'b0;
    check_value("read response", 64'(resp), 64'd0);
  endtask

  task automatic send_item(input logic [31:0] data);
    @(posedge aclk);
    item_req  <= 1'b1;
    item_data <= data;
    do
      @(negedge aclk);
    while (!item_ack);
    @(posedge aclk);
    item_req <= 1'b0;
    do
      @(negedge aclk);
    while (item_ack);
  endtask

  // Start an estimate and poll until result valid
  task automatic run_estimate();
    logic [63:0] st;
    axil_write(hll_pkg::REG_CTRL, 64'h2);
    do
      axil_read(hll_pkg::REG_STATUS, st);
    while (!st[0]);
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    cmp_what    = what;
    cmp_got     = got;
    cmp_exp     = exp;
    cmp_req_cnt = cmp_req_cnt + 1;
    wait (cmp_ack_cnt == cmp_req_cnt);
  endtask

  task automatic end_test(input int num, input string name);
    if (mismatch_cnt == test_start_mm)
      $display("test %0d %s: ok", num, name);
    else
    begin
      fail_tests = fail_tests + 1;
      $display("test %0d %s: FAILED, %0d mismatches", num, name,
               mismatch_cnt - test_start_mm);
    end
    test_start_mm = mismatch_cnt;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    aresetn   <= 1'b0;
    axil_req  <= '0;
    item_req  <= 1'b0;
    item_data <= '0;
    lfsr_state = 32'd38;
    for (int i = 0; i < NUM_BUCKETS; i++)
      ref_bucket[i] = 0;
    repeat (10) @(posedge aclk);
    aresetn <= 1'b1;
    repeat (2) @(posedge aclk);

    axil_read(hll_pkg::REG_STATUS, rd_data);
    check_value("status after reset", rd_data, 64'd0);
    axil_read(hll_pkg::REG_RESULT, rd_data);
    check_value("result after reset", rd_data, 64'd0);
    axil_read(hll_pkg::REG_CTRL, rd_data);
    check_value("control after reset", rd_data, 64'd0);
    axil_read(8'h40, rd_data);
    check_value("unmapped address", rd_data, 64'd0);
    @(negedge aclk);
    check_value("item_ack after reset", 64'(item_ack), 64'd0);
    end_test(1, "reset values");

    run_estimate();
    axil_read(hll_pkg::REG_RESULT, rd_data);
    check_value("empty sketch result", rd_data, EMPTY_RESULT);
    axil_read(hll_pkg::REG_STATUS, rd_data);
    check_value("status after estimate", rd_data, 64'h1);
    end_test(2, "empty estimate");

    send_item(32'hdead_beef);
    ref_add(32'hdead_beef);
    run_estimate();
    axil_read(hll_pkg::REG_RESULT, rd_data);
    check_value("single item result", rd_data, ref_result());
    end_test(3, "single item");

    // 8 random bits per item, so values repeat
    for (int i = 0; i < NUM_ITEMS; i++)
    begin
      random_bits(8, items[i]);
      send_item(items[i]);
      ref_add(items[i]);
    end
    run_estimate();
    axil_read(hll_pkg::REG_RESULT, rd_data);
    saved_result = ref_result();
    check_value("random items result", rd_data, saved_result);
    end_test(4, "random items");

    for (int i = 0; i < NUM_ITEMS; i++)
    begin
      send_item(items[i]);
      ref_add(items[i]);
    end
    run_estimate();
    axil_read(hll_pkg::REG_RESULT, rd_data);
    check_value("repeated items result", rd_data, ref_result());
    check_value("repeated items vs first pass", rd_data, saved_result);
    end_test(5, "repeated items");

    axil_write(hll_pkg::REG_CTRL, 64'h1);
    for (int i = 0; i < NUM_BUCKETS; i++)
      ref_bucket[i] = 0;
    axil_read(hll_pkg::REG_STATUS, rd_data);
    check_value("status after clear", rd_data, 64'd0);
    run_estimate();
    axil_read(hll_pkg::REG_RESULT, rd_data);
    check_value("result after clear", rd_data, EMPTY_RESULT);
    end_test(6, "clear");

    $display("summary: %0d tests, %0d failing, %0d checks, %0d mismatches",
             NUM_TESTS, fail_tests, check_cnt, mismatch_cnt);
    if (fail_tests == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

// File: hll_top.f
source/hll_pkg.sv
source/hll_slave.sv
source/hll_item_port.sv
source/hll_hash.sv
source/hll_sketch.sv
source/hll_estimator.sv
source/hll_top.sv
testbench/hll_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the HLL sketch testbench with Verilator, run it and
# decide pass or fail from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module hll_tb -f hll_top.f -o hll_sim \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/hll_sim)
echo "$out"
echo "$out" | grep -qx "all tests passed" \
  && echo "result: PASS" \
  || { echo "result: FAIL"; exit 1; }
